// ==== valu_pkg.sv ====
// Vector ALU package
// Sizes, scalar types, opcode and element-width encodings, and the
// instruction and register-file write records shared by every block
// of the single-lane SIMD integer ALU
package valu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Datapath word and its byte enables
  localparam int unsigned ElenBits = 64;
  localparam int unsigned StrbBits = ElenBits / 8;

  // Queue depths
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;

  // Instruction ids and register geometry
  localparam int unsigned NrInsnIds = 8;
  localparam int unsigned VRegWords = 8;
  localparam int unsigned MaxVl     = 64;

  // Pointer and occupancy widths of the two queues
  localparam int unsigned InsnPntBits   = $clog2(InsnQueueDepth);
  localparam int unsigned InsnCntBits   = $clog2(InsnQueueDepth + 1);
  localparam int unsigned ResultPntBits = $clog2(ResultQueueDepth);
  localparam int unsigned ResultCntBits = $clog2(ResultQueueDepth + 1);

  ////////////////////
  // Scalar types
  ////////////////////

  typedef logic [ElenBits-1:0]              elen_t;
  typedef logic [StrbBits-1:0]              strb_t;
  typedef logic [$clog2(MaxVl+1)-1:0]       vl_t;
  typedef logic [4:0]                       vreg_t;
  typedef logic [7:0]                       vaddr_t;
  typedef logic [$clog2(NrInsnIds)-1:0]     insn_id_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VXOR,
    VMINU,
    VMAXU
  } valu_op_e;

  // Element width, log2 of the bytes per element
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  ////////////////////
  // Records
  ////////////////////

  // One vector instruction
  typedef struct packed {
    valu_op_e op;
    vsew_e    vsew;
    vl_t      vl;
    vreg_t    vd;
    insn_id_t id;
    logic     use_scalar;
    elen_t    scalar;
  } valu_insn_t;

  // One register-file write
  typedef struct packed {
    vaddr_t   addr;
    insn_id_t id;
    elen_t    wdata;
    strb_t    be;
  } valu_result_t;

endpackage

// ==== valu_insn_queue.sv ====
// Vector ALU instruction queue
// Ring of in-flight instructions with one pointer per phase:
// accept writes a slot, issue walks the operands, commit retires
// results. Separate issue and commit counts give the occupancy.
`timescale 1ns/1ps

module valu_insn_queue (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  valu_pkg::valu_insn_t  insn_i,
  input  logic                  accept_i,
  input  logic                  issue_done_i,
  input  logic                  commit_done_i,
  output valu_pkg::valu_insn_t  issue_insn_o,
  output valu_pkg::valu_insn_t  commit_insn_o,
  output logic                  issue_valid_o,
  output logic                  commit_valid_o,
  output logic                  full_o
);

  // Instruction storage
  valu_pkg::valu_insn_t [valu_pkg::InsnQueueDepth-1:0] mem_q;

  // Phase pointers, wrapping at the power-of-two depth
  logic [valu_pkg::InsnPntBits-1:0] accept_pnt_q;
  logic [valu_pkg::InsnPntBits-1:0] issue_pnt_q;
  logic [valu_pkg::InsnPntBits-1:0] commit_pnt_q;

  // Instructions still to issue and still to commit
  logic [valu_pkg::InsnCntBits-1:0] issue_cnt_q;
  logic [valu_pkg::InsnCntBits-1:0] commit_cnt_q;

  ////////////////////
  // Status
  ////////////////////

  // A slot frees only once its last word is committed
  assign full_o         = (commit_cnt_q == valu_pkg::InsnCntBits'(valu_pkg::InsnQueueDepth));
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_valid_o = (commit_cnt_q != '0);

  // Heads of the two phases
  assign issue_insn_o  = mem_q[issue_pnt_q];
  assign commit_insn_o = mem_q[commit_pnt_q];

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (accept_i) begin
      mem_q[accept_pnt_q] <= insn_i;
    end
  end

  ////////////////////
  // Pointers, counts
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept_i) begin
        accept_pnt_q <= accept_pnt_q + 1'b1;
      end
      if (issue_done_i) begin
        issue_pnt_q <= issue_pnt_q + 1'b1;
      end
      if (commit_done_i) begin
        commit_pnt_q <= commit_pnt_q + 1'b1;
      end
      // Accept and retire may coincide
      issue_cnt_q  <= issue_cnt_q + valu_pkg::InsnCntBits'(accept_i)
                      - valu_pkg::InsnCntBits'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + valu_pkg::InsnCntBits'(accept_i)
                      - valu_pkg::InsnCntBits'(commit_done_i);
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Control must honour the full flag
  a_no_accept_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) accept_i |-> !full_o
  ) else $error("Instruction accepted while queue full");

  // Issue may only finish an instruction that was accepted earlier
  a_issue_has_insn : assert property (
    @(posedge clk_i) disable iff (!rst_ni) issue_done_i |-> issue_valid_o
  ) else $error("Issue done without a waiting instruction");

endmodule

// ==== valu_simd_alu.sv ====
// SIMD integer ALU
// Combinational datapath for one 64-bit word. Operand a is vs1 or the
// scalar replicated to the element width, operand b is vs2. The opcode
// applies per element, carries stop at element borders.
`timescale 1ns/1ps

module valu_simd_alu (
  input  logic                        issue_en_i,
  input  valu_pkg::valu_insn_t        insn_i,
  input  valu_pkg::elen_t       [1:0] operand_i,
  output valu_pkg::elen_t             result_o
);

  valu_pkg::elen_t scalar_rep;
  valu_pkg::elen_t op_a;
  valu_pkg::elen_t op_b;
  // Full-width result of one element, sliced down afterwards
  valu_pkg::elen_t elem_res;

  // One element, operands zero extended to the word
  // Sub and the unsigned compares stay exact in the low bits
  function automatic valu_pkg::elen_t elem_op(valu_pkg::valu_op_e op,
                                              valu_pkg::elen_t a,
                                              valu_pkg::elen_t b);
    case (op)
      valu_pkg::VADD:  return b + a;
      valu_pkg::VSUB:  return b - a;
      valu_pkg::VAND:  return b & a;
      valu_pkg::VOR:   return b | a;
      valu_pkg::VXOR:  return b ^ a;
      valu_pkg::VMINU: return (a < b) ? a : b;
      valu_pkg::VMAXU: return (a > b) ? a : b;
      default:         return '0;
    endcase
  endfunction

  ////////////////////
  // Operand select
  ////////////////////

  // Scalar copied into every element slot
  always_comb begin
    case (insn_i.vsew)
      valu_pkg::EW8:  scalar_rep = {8{insn_i.scalar[7:0]}};
      valu_pkg::EW16: scalar_rep = {4{insn_i.scalar[15:0]}};
      valu_pkg::EW32: scalar_rep = {2{insn_i.scalar[31:0]}};
      default:        scalar_rep = insn_i.scalar;
    endcase
  end

  // Hold the operands quiet when nothing issues
  assign op_a = !issue_en_i       ? '0         :
                insn_i.use_scalar ? scalar_rep : operand_i[0];
  assign op_b = issue_en_i ? operand_i[1] : '0;

  ////////////////////
  // Per-element ops
  ////////////////////

  always_comb begin
    result_o = '0;
    elem_res = '0;
    case (insn_i.vsew)
      valu_pkg::EW8: begin
        for (int i = 0; i < 8; i++) begin
          elem_res = elem_op(insn_i.op, valu_pkg::elen_t'(op_a[8*i +: 8]),
                             valu_pkg::elen_t'(op_b[8*i +: 8]));
          result_o[8*i +: 8] = elem_res[7:0];
        end
      end
      valu_pkg::EW16: begin
        for (int i = 0; i < 4; i++) begin
          elem_res = elem_op(insn_i.op, valu_pkg::elen_t'(op_a[16*i +: 16]),
                             valu_pkg::elen_t'(op_b[16*i +: 16]));
          result_o[16*i +: 16] = elem_res[15:0];
        end
      end
      valu_pkg::EW32: begin
        for (int i = 0; i < 2; i++) begin
          elem_res = elem_op(insn_i.op, valu_pkg::elen_t'(op_a[32*i +: 32]),
                             valu_pkg::elen_t'(op_b[32*i +: 32]));
          result_o[32*i +: 32] = elem_res[31:0];
        end
      end
      default: begin
        // One element fills the word
        elem_res = elem_op(insn_i.op, op_a, op_b);
        result_o = elem_res;
      end
    endcase
  end

endmodule

// ==== valu_result_queue.sv ====
// Vector ALU result queue
// Two-entry circular FIFO of register-file writes. The head is
// requested while the FIFO holds data and pops on the grant.
`timescale 1ns/1ps

module valu_result_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   push_i,
  input  valu_pkg::valu_result_t push_data_i,
  input  logic                   result_gnt_i,
  output logic                   full_o,
  output logic                   result_req_o,
  output valu_pkg::valu_result_t result_o
);

  // Buffered writes
  valu_pkg::valu_result_t [valu_pkg::ResultQueueDepth-1:0] mem_q;

  logic [valu_pkg::ResultPntBits-1:0] wr_pnt_q;
  logic [valu_pkg::ResultPntBits-1:0] rd_pnt_q;
  logic [valu_pkg::ResultCntBits-1:0] cnt_q;
  logic                               pop;

  ////////////////////
  // Status
  ////////////////////

  assign full_o       = (cnt_q == valu_pkg::ResultCntBits'(valu_pkg::ResultQueueDepth));
  assign result_req_o = (cnt_q != '0);
  // Head stays put until granted
  assign result_o     = mem_q[rd_pnt_q];
  assign pop          = result_gnt_i && result_req_o;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= push_data_i;
    end
  end

  ////////////////////
  // Pointers, count
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Depth is a power of two so the pointers wrap on their own
      if (push_i) begin
        wr_pnt_q <= wr_pnt_q + 1'b1;
      end
      if (pop) begin
        rd_pnt_q <= rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + valu_pkg::ResultCntBits'(push_i) - valu_pkg::ResultCntBits'(pop);
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Issue must stall on a full FIFO
  a_no_push_full : assert property (
    @(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o
  ) else $error("Result pushed into full queue");

  // Register-file side protocol
  a_gnt_with_req : assert property (
    @(posedge clk_i) disable iff (!rst_ni) result_gnt_i |-> result_req_o
  ) else $error("Grant without request");

  // Pending write held stable until granted
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    result_req_o && !result_gnt_i |=> result_req_o && $stable(result_o)
  ) else $error("Request dropped or changed before grant");

endmodule

// ==== valu_ctrl.sv ====
// Vector ALU control
// Accept handshake, issue decision with operand acknowledge, and the
// commit side that counts granted elements. Forms each register-file
// write from the ALU result, the word address and the byte enables.
`timescale 1ns/1ps

module valu_ctrl (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         insn_valid_i,
  input  logic                   [1:0] operand_valid_i,
  input  logic                         result_gnt_i,
  input  logic                         rq_full_i,
  input  valu_pkg::valu_insn_t         issue_insn_i,
  input  valu_pkg::valu_insn_t         commit_insn_i,
  input  logic                         issue_valid_i,
  input  logic                         commit_valid_i,
  input  logic                         iq_full_i,
  input  valu_pkg::elen_t              alu_result_i,
  output logic                         ready_o,
  output logic                         accept_o,
  output logic                         issue_done_o,
  output logic                         commit_done_o,
  output logic                   [1:0] operand_ready_o,
  output logic                         issue_en_o,
  output logic                         push_o,
  output valu_pkg::valu_result_t       push_data_o,
  output logic [valu_pkg::NrInsnIds-1:0] done_o
);

  // Issue side
  valu_pkg::vl_t issue_rem, issue_rem_q;
  valu_pkg::vl_t issue_epw, issue_elems, issue_bytes;
  valu_pkg::vl_t issue_word_q;
  logic          issue_first_q;
  // Commit side
  valu_pkg::vl_t commit_rem, commit_rem_q;
  valu_pkg::vl_t commit_epw;
  logic          commit_first_q;

  // 8, 4, 2 or 1 elements per word
  function automatic valu_pkg::vl_t elems_per_word(valu_pkg::vsew_e sew);
    return valu_pkg::vl_t'(valu_pkg::StrbBits >> sew);
  endfunction

  ////////////////////
  // Accept
  ////////////////////

  assign ready_o  = !iq_full_i;
  assign accept_o = insn_valid_i && !iq_full_i;

  ////////////////////
  // Issue
  ////////////////////

  // A fresh head loads its vl straight from the queue
  assign issue_rem   = issue_first_q ? issue_insn_i.vl : issue_rem_q;
  assign issue_epw   = elems_per_word(issue_insn_i.vsew);
  assign issue_elems = (issue_rem < issue_epw) ? issue_rem : issue_epw;
  assign issue_bytes = issue_elems << issue_insn_i.vsew;

  // vs2 always needed, vs1 only without the scalar
  assign issue_en_o = issue_valid_i && !rq_full_i && operand_valid_i[1] &&
                      (issue_insn_i.use_scalar || operand_valid_i[0]);
  assign operand_ready_o = {issue_en_o, issue_en_o && !issue_insn_i.use_scalar};
  assign issue_done_o    = issue_en_o && (issue_rem <= issue_epw);
  assign push_o          = issue_en_o;

  // Write record for this word
  always_comb begin
    push_data_o.addr  = valu_pkg::vaddr_t'(issue_insn_i.vd) *
                        valu_pkg::vaddr_t'(valu_pkg::VRegWords) +
                        valu_pkg::vaddr_t'(issue_word_q);
    push_data_o.id    = issue_insn_i.id;
    push_data_o.wdata = alu_result_i;
    // Low bytes of the live elements, the whole word when full
    for (int b = 0; b < valu_pkg::StrbBits; b++) begin
      push_data_o.be[b] = (valu_pkg::vl_t'(b) < issue_bytes);
    end
  end

  ////////////////////
  // Commit
  ////////////////////

  assign commit_rem    = commit_first_q ? commit_insn_i.vl : commit_rem_q;
  assign commit_epw    = elems_per_word(commit_insn_i.vsew);
  // Last word of the instruction granted
  assign commit_done_o = result_gnt_i && commit_valid_i && (commit_rem <= commit_epw);

  always_comb begin
    done_o = '0;
    if (commit_done_o) begin
      done_o[commit_insn_i.id] = 1'b1;
    end
  end

  ////////////////////
  // Counters
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_first_q  <= 1'b1;
      issue_rem_q    <= '0;
      issue_word_q   <= '0;
      commit_first_q <= 1'b1;
      commit_rem_q   <= '0;
    end else begin
      if (issue_en_o) begin
        if (issue_done_o) begin
          // Next head starts from its own vl at word 0
          issue_first_q <= 1'b1;
          issue_word_q  <= '0;
        end else begin
          issue_first_q <= 1'b0;
          issue_rem_q   <= issue_rem - issue_epw;
          issue_word_q  <= issue_word_q + 1'b1;
        end
      end
      if (result_gnt_i) begin
        if (commit_done_o) begin
          commit_first_q <= 1'b1;
        end else begin
          commit_first_q <= 1'b0;
          commit_rem_q   <= commit_rem - commit_epw;
        end
      end
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // Every granted word belongs to an instruction still in the queue
  a_gnt_has_commit : assert property (
    @(posedge clk_i) disable iff (!rst_ni) result_gnt_i |-> commit_valid_i
  ) else $error("Grant with no instruction to commit");

endmodule

// ==== valu_top.sv ====
// Vector ALU top level
// Single-lane SIMD integer ALU: instruction queue, control, the
// combinational datapath and the result FIFO toward the register file
`timescale 1ns/1ps

module valu_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Instructions
  input  valu_pkg::valu_insn_t           insn_i,
  input  logic                           insn_valid_i,
  output logic                           ready_o,
  // Operands, index 0 is vs1 and index 1 is vs2
  input  valu_pkg::elen_t          [1:0] operand_i,
  input  logic                     [1:0] operand_valid_i,
  output logic                     [1:0] operand_ready_o,
  // Register-file writes
  output valu_pkg::valu_result_t         result_o,
  output logic                           result_req_o,
  input  logic                           result_gnt_i,
  // Completion
  output logic [valu_pkg::NrInsnIds-1:0] done_o
);

  valu_pkg::valu_insn_t   issue_insn, commit_insn;
  logic                   issue_valid, commit_valid, iq_full;
  logic                   accept, issue_done, commit_done;
  logic                   issue_en, push, rq_full;
  valu_pkg::elen_t        alu_result;
  valu_pkg::valu_result_t push_data;

  valu_ctrl u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .insn_valid_i    (insn_valid_i),
    .operand_valid_i (operand_valid_i),
    .result_gnt_i    (result_gnt_i),
    .rq_full_i       (rq_full),
    .issue_insn_i    (issue_insn),
    .commit_insn_i   (commit_insn),
    .issue_valid_i   (issue_valid),
    .commit_valid_i  (commit_valid),
    .iq_full_i       (iq_full),
    .alu_result_i    (alu_result),
    .ready_o         (ready_o),
    .accept_o        (accept),
    .issue_done_o    (issue_done),
    .commit_done_o   (commit_done),
    .operand_ready_o (operand_ready_o),
    .issue_en_o      (issue_en),
    .push_o          (push),
    .push_data_o     (push_data),
    .done_o          (done_o)
  );

  valu_insn_queue u_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_i         (insn_i),
    .accept_i       (accept),
    .issue_done_i   (issue_done),
    .commit_done_i  (commit_done),
    .issue_insn_o   (issue_insn),
    .commit_insn_o  (commit_insn),
    .issue_valid_o  (issue_valid),
    .commit_valid_o (commit_valid),
    .full_o         (iq_full)
  );

  valu_simd_alu u_simd_alu (
    .issue_en_i (issue_en),
    .insn_i     (issue_insn),
    .operand_i  (operand_i),
    .result_o   (alu_result)
  );

  valu_result_queue u_result_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_i       (push),
    .push_data_i  (push_data),
    .result_gnt_i (result_gnt_i),
    .full_o       (rq_full),
    .result_req_o (result_req_o),
    .result_o     (result_o)
  );

endmodule

// ==== valu_tb.sv ====
// Vector ALU testbench
// Applies a table of vector instructions with random operand words,
// models each word per element and checks every register-file write,
// the operand handshakes, back-pressure and the done pulses
`timescale 1ns/1ps

module valu_tb;

  localparam int AcceptTimeout = 2000;
  localparam int DrainTimeout  = 5000;
  // Grant delay code that draws a fresh delay per word
  localparam int RandomDelay   = 255;
  localparam int HoldDelay     = 25;

  logic                                clk = 1'b0;
  logic                                rst_n;
  valu_pkg::valu_insn_t                insn_i;
  logic                                insn_valid_i;
  logic                                ready_o;
  valu_pkg::elen_t               [1:0] operand_i;
  logic                          [1:0] operand_valid_i;
  logic                          [1:0] operand_ready_o;
  valu_pkg::valu_result_t              result_o;
  logic                                result_req_o;
  logic                                result_gnt_i;
  logic [valu_pkg::NrInsnIds-1:0]      done_o;

  integer seed = 32'h64d399cf;
  logic   feed_en = 1'b0;

  // Stimulus table, one row per instruction
  valu_pkg::valu_insn_t tbl_insn[$];
  int                   tbl_gdelay[$];
  int                   cur_gdelay;

  // Model state: instructions waiting to issue, expected writes and done ids
  valu_pkg::valu_insn_t   iss_q[$];
  int                     iss_gd[$];
  int                     iss_word = 0;
  valu_pkg::valu_result_t exp_q[$];
  logic                   exp_last[$];
  int                     exp_delay[$];
  valu_pkg::insn_id_t     done_q[$];
  int                     inflight = 0;
  int                     gnt_wait = 0;
  logic                   gnt_loaded = 1'b0;
  logic                   saw_iq_full = 1'b0;
  logic                   saw_rq_stall = 1'b0;

  always #2 clk = ~clk;

  valu_top dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .insn_i          (insn_i),
    .insn_valid_i    (insn_valid_i),
    .ready_o         (ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_o        (result_o),
    .result_req_o    (result_req_o),
    .result_gnt_i    (result_gnt_i),
    .done_o          (done_o)
  );

  ////////////////////
  // Failure handling
  ////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_result(input valu_pkg::valu_result_t got,
                              input valu_pkg::valu_result_t exp);
    if (got !== exp) begin
      abort_run($sformatf({"Error at %0t ns: result mismatch, got addr %0d id %0d ",
                           "data %h be %b, expected addr %0d id %0d data %h be %b"},
                          $time, got.addr, got.id, got.wdata, got.be,
                          exp.addr, exp.id, exp.wdata, exp.be));
    end
  endtask

  task automatic check_done(input logic [valu_pkg::NrInsnIds-1:0] got,
                            input logic pulse, input valu_pkg::insn_id_t id);
    logic [valu_pkg::NrInsnIds-1:0] exp;
    exp = pulse ? (valu_pkg::NrInsnIds'(1) << id) : '0;
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: done_o is %b, expected %b",
                          $time, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t ns: %s is %b, expected %b",
                          $time, what, got, exp));
    end
  endtask

  ////////////////////
  // Reference model
  ////////////////////

  // Scalar copied into each element slot of width 8 << sew
  function automatic valu_pkg::elen_t replicate(valu_pkg::elen_t s, valu_pkg::vsew_e sew);
    int              w;
    valu_pkg::elen_t mask;
    valu_pkg::elen_t acc;
    w    = 8 << int'(sew);
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    acc  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      acc = acc | ((s & mask) << (e * w));
    end
    return acc;
  endfunction

  // Per-element result, each element masked so no carry leaks upward
  function automatic valu_pkg::elen_t model_word(valu_pkg::valu_op_e op,
                                                 valu_pkg::vsew_e sew,
                                                 valu_pkg::elen_t a,
                                                 valu_pkg::elen_t b);
    int              w;
    valu_pkg::elen_t mask;
    valu_pkg::elen_t ea;
    valu_pkg::elen_t eb;
    valu_pkg::elen_t er;
    valu_pkg::elen_t acc;
    w    = 8 << int'(sew);
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    acc  = '0;
    for (int e = 0; e < 64 / w; e++) begin
      ea = (a >> (e * w)) & mask;
      eb = (b >> (e * w)) & mask;
      case (op)
        valu_pkg::VADD:  er = eb + ea;
        valu_pkg::VSUB:  er = eb - ea;
        valu_pkg::VAND:  er = eb & ea;
        valu_pkg::VOR:   er = eb | ea;
        valu_pkg::VXOR:  er = eb ^ ea;
        valu_pkg::VMINU: er = (ea < eb) ? ea : eb;
        valu_pkg::VMAXU: er = (ea > eb) ? ea : eb;
        default:         er = '0;
      endcase
      acc = acc | ((er & mask) << (e * w));
    end
    return acc;
  endfunction

  task automatic add_row(input int op, input int sew, input int vl, input int vd,
                         input logic use_scalar, input int gdelay);
    valu_pkg::valu_insn_t row;
    logic [31:0]          hi;
    logic [31:0]          lo;
    hi             = $random(seed);
    lo             = $random(seed);
    row.op         = valu_pkg::valu_op_e'(op);
    row.vsew       = valu_pkg::vsew_e'(sew);
    row.vl         = valu_pkg::vl_t'(vl);
    row.vd         = valu_pkg::vreg_t'(vd);
    row.id         = valu_pkg::insn_id_t'(tbl_insn.size() % valu_pkg::NrInsnIds);
    row.use_scalar = use_scalar;
    row.scalar     = {hi, lo};
    tbl_insn.push_back(row);
    tbl_gdelay.push_back(gdelay);
  endtask

  ////////////////////
  // Operand and grant drive
  ////////////////////

  always @(negedge clk) begin : drive_side
    logic [31:0] hi;
    logic [31:0] lo;
    if (!feed_en) begin
      operand_valid_i = '0;
      result_gnt_i    = 1'b0;
    end else begin
      // Valid about three cycles out of four per operand
      operand_valid_i[1] = (($random(seed) & 3) != 0);
      operand_valid_i[0] = (($random(seed) & 3) != 0);
      hi = $random(seed);
      lo = $random(seed);
      operand_i[1] = {hi, lo};
      hi = $random(seed);
      lo = $random(seed);
      operand_i[0] = {hi, lo};
      // Delay for the head word is drawn once when its request appears
      if (result_req_o && !gnt_loaded && exp_delay.size() != 0) begin
        gnt_wait   = (exp_delay[0] == RandomDelay) ? ($unsigned($random(seed)) % 6)
                                                   : exp_delay[0];
        gnt_loaded = 1'b1;
      end
      if (result_req_o && gnt_loaded && gnt_wait == 0) begin
        result_gnt_i = 1'b1;
      end else begin
        result_gnt_i = 1'b0;
        if (gnt_loaded && gnt_wait > 0) begin
          gnt_wait--;
        end
      end
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  always @(posedge clk) begin : monitor
    valu_pkg::valu_insn_t   head;
    valu_pkg::valu_result_t exp_word;
    valu_pkg::elen_t        op_a;
    logic                   want_issue;
    int                     epw;
    int                     rem;
    int                     bytes;
    if (rst_n && feed_en) begin
      check_flag(ready_o, inflight != valu_pkg::InsnQueueDepth, "ready_o");
      if (inflight == valu_pkg::InsnQueueDepth) saw_iq_full = 1'b1;
      // Expected issue decision from the state before this edge
      head       = '0;
      want_issue = 1'b0;
      if (iss_q.size() != 0) begin
        head       = iss_q[0];
        want_issue = (exp_q.size() < valu_pkg::ResultQueueDepth) && operand_valid_i[1] &&
                     (head.use_scalar || operand_valid_i[0]);
      end
      check_flag(operand_ready_o[1], want_issue, "operand_ready_o[1]");
      check_flag(operand_ready_o[0], want_issue && !head.use_scalar, "operand_ready_o[0]");
      // Head write must be present and unchanged until granted
      check_flag(result_req_o, exp_q.size() != 0, "result_req_o");
      if (exp_q.size() == valu_pkg::ResultQueueDepth && !result_gnt_i) saw_rq_stall = 1'b1;
      if (result_req_o && exp_q.size() != 0) check_result(result_o, exp_q[0]);
      if (result_gnt_i && exp_q.size() != 0) begin
        if (exp_last[0]) begin
          check_done(done_o, 1'b1, done_q[0]);
          void'(done_q.pop_front());
          inflight--;
        end else begin
          check_done(done_o, 1'b0, '0);
        end
        void'(exp_q.pop_front());
        void'(exp_last.pop_front());
        void'(exp_delay.pop_front());
        gnt_loaded = 1'b0;
      end else begin
        check_done(done_o, 1'b0, '0);
      end
      if (want_issue) begin
        epw   = 8 >> int'(head.vsew);
        rem   = int'(head.vl) - iss_word * epw;
        bytes = ((rem < epw) ? rem : epw) << int'(head.vsew);
        op_a  = head.use_scalar ? replicate(head.scalar, head.vsew) : operand_i[0];
        exp_word.addr  = valu_pkg::vaddr_t'(head.vd * valu_pkg::VRegWords + iss_word);
        exp_word.id    = head.id;
        exp_word.wdata = model_word(head.op, head.vsew, op_a, operand_i[1]);
        exp_word.be    = (bytes >= 8) ? '1 : valu_pkg::strb_t'((1 << bytes) - 1);
        exp_q.push_back(exp_word);
        exp_last.push_back(rem <= epw);
        exp_delay.push_back(iss_gd[0]);
        if (rem <= epw) begin
          done_q.push_back(head.id);
          void'(iss_q.pop_front());
          void'(iss_gd.pop_front());
          iss_word = 0;
        end else begin
          iss_word++;
        end
      end
      if (insn_valid_i && ready_o) begin
        iss_q.push_back(insn_i);
        iss_gd.push_back(cur_gdelay);
        inflight++;
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin : main_seq
    int   waited;
    logic accepted;
    rst_n           = 1'b0;
    insn_i          = '0;
    insn_valid_i    = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = 1'b0;
    cur_gdelay      = 0;
    // Every opcode at every width, partial vl and scalar rows mixed in
    for (int op = 0; op < 7; op++) begin
      for (int sew = 0; sew < 4; sew++) begin
        add_row(op, sew, 1 + ((op * 4 + sew) * 5) % 20, (op * 4 + sew) % 32,
                ((op + sew) % 3) == 0, ((op + sew) % 2 == 0) ? 0 : RandomDelay);
      end
    end
    for (int sew = 0; sew < 4; sew++) begin
      add_row(sew, sew, 3 + 2 * sew, 10 + sew, 1'b1, RandomDelay);
    end
    add_row(0, 0, 64, 31, 1'b0, 0);
    // Long grant holds fill both queues
    for (int i = 0; i < 5; i++) begin
      add_row(i, 2, 6, 20 + i, i[0], HoldDelay);
    end

    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    check_flag(ready_o, 1'b1, "ready_o after reset");
    check_flag(result_req_o, 1'b0, "result_req_o after reset");
    check_flag(operand_ready_o[0], 1'b0, "operand_ready_o[0] after reset");
    check_flag(operand_ready_o[1], 1'b0, "operand_ready_o[1] after reset");
    check_done(done_o, 1'b0, '0);
    feed_en <= 1'b1;

    for (int i = 0; i < tbl_insn.size(); i++) begin
      @(negedge clk);
      insn_i       = tbl_insn[i];
      cur_gdelay   = tbl_gdelay[i];
      insn_valid_i = 1'b1;
      accepted     = 1'b0;
      waited       = 0;
      while (!accepted) begin
        @(posedge clk);
        accepted = ready_o;
        waited++;
        if (!accepted && waited > AcceptTimeout) begin
          abort_run($sformatf("Timeout: instruction %0d was never accepted", i));
        end
      end
    end
    @(negedge clk);
    insn_valid_i = 1'b0;

    waited = 0;
    while (inflight != 0 || exp_q.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > DrainTimeout) begin
        abort_run("Timeout: results or done pulses still missing at the end");
      end
    end
    if (!saw_iq_full || !saw_rq_stall) begin
      abort_run("The instruction queue or the result queue never filled");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

// ==== verilog.f ====
valu_pkg.sv
valu_insn_queue.sv
valu_simd_alu.sv
valu_result_queue.sv
valu_ctrl.sv
valu_top.sv
valu_tb.sv
